// ==== logic/i2c_ctrl_pkg.sv ====
/*
 * i2c master host-side definitions
 * register offsets, field positions and axi4-lite response codes
 */
package i2c_ctrl_pkg;

	// axi4-lite bus widths
	localparam int axi_data_w = 32;
	localparam int axi_addr_w = 5;
	localparam int axi_strb_w = axi_data_w / 8;

	// register offsets
	localparam logic [axi_addr_w-1:0] reg_dev_addr = 5'h00;
	localparam logic [axi_addr_w-1:0] reg_mem_addr = 5'h04;
	localparam logic [axi_addr_w-1:0] reg_wr_data  = 5'h08;
	localparam logic [axi_addr_w-1:0] reg_command  = 5'h0c;
	localparam logic [axi_addr_w-1:0] reg_status   = 5'h10;

	// 7-bit device address sits in bits 7:1, bit 0 reads zero
	localparam int dev_addr_lsb = 1;

	// command bits, write wins when both are set
	localparam int cmd_wr_bit = 0;
	localparam int cmd_rd_bit = 1;

	// status word layout
	localparam int st_busy_bit = 0;
	localparam int st_fail_bit = 1;
	localparam int st_hist_lsb = 4;
	localparam int st_rdv_bit  = 8;
	localparam int st_rdd_lsb  = 16;

	// response codes
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// ==== logic/i2c_bus_pkg.sv ====
/*
 * i2c master bus-side definitions
 * symbol codes, bus timing and symbol string length
 */
package i2c_bus_pkg;

	// bus symbols, one per bit period
	localparam logic [2:0] sym_idle  = 3'b000;
	localparam logic [2:0] sym_start = 3'b001;
	localparam logic [2:0] sym_stop  = 3'b010;
	localparam logic [2:0] sym_grab  = 3'b011;
	// check looks for a low acknowledge bit
	localparam logic [2:0] sym_check = 3'b100;
	// bit 0 of a send code is the bit driven onto sda
	localparam logic [2:0] sym_send0 = 3'b110;
	localparam logic [2:0] sym_send1 = 3'b111;

	// system clock and scl rate in hz
	localparam int clk_freq = 10_000_000;
	localparam int scl_freq = 100_000;

	// system clocks per bit period
	localparam int bit_cycle = clk_freq / scl_freq;
	localparam int cntr_w    = $clog2(bit_cycle);

	// quarter boundaries of the period counter
	localparam logic [cntr_w-1:0] tick_q1 = cntr_w'(bit_cycle / 4 - 1);
	localparam logic [cntr_w-1:0] tick_q2 = cntr_w'(bit_cycle / 2 - 1);
	localparam logic [cntr_w-1:0] tick_q3 = cntr_w'((bit_cycle * 3) / 4 - 1);
	localparam logic [cntr_w-1:0] tick_q4 = cntr_w'(bit_cycle - 1);

	// longest transfer is the random read at 42 symbols
	localparam int max_syms = 44;

endpackage

// ==== logic/i2c_bit_timer.sv ====
/*
 * i2c bit timer
 * free-running bit period counter with four quarter-phase tick pulses
 */
`timescale 1ns/1ps

module i2c_bit_timer (
	input  logic clk,
	input  logic user_mode_sync,
	output logic tick_q1,
	output logic tick_q2,
	output logic tick_q3,
	output logic tick_q4
);
	import i2c_bus_pkg::*;

	logic [cntr_w-1:0] bit_cntr;

	// tick pattern across one bit period
	//   q1  sda may change
	//   q2  scl rises
	//   q3  sda sampled
	//   q4  scl falls, next symbol
	always_ff @(posedge clk or negedge user_mode_sync) begin
		if (!user_mode_sync) begin
			bit_cntr <= '0;
			tick_q1  <= 1'b0;
			tick_q2  <= 1'b0;
			tick_q3  <= 1'b0;
			tick_q4  <= 1'b0;
		end else begin
			if (bit_cntr == i2c_bus_pkg::tick_q4) begin
				bit_cntr <= '0;
			end else begin
				bit_cntr <= bit_cntr + 1'b1;
			end
			// ticks land one clock after the matching count
			tick_q1 <= (bit_cntr == i2c_bus_pkg::tick_q1);
			tick_q2 <= (bit_cntr == i2c_bus_pkg::tick_q2);
			tick_q3 <= (bit_cntr == i2c_bus_pkg::tick_q3);
			tick_q4 <= (bit_cntr == i2c_bus_pkg::tick_q4);
		end
	end

endmodule

// ==== logic/i2c_sequencer.sv ====
/*
 * i2c transfer sequencer
 * loads the symbol string for a write or random read, shifts it once
 * per bit period and tracks busy, done, read data and acknowledge state
 */
`timescale 1ns/1ps

module i2c_sequencer (
	input  logic       clk,
	input  logic       user_mode_sync,
	input  logic       cmd_wr,
	input  logic       cmd_rd,
	input  logic [6:0] dev_addr,
	input  logic [7:0] mem_addr,
	input  logic [7:0] wr_data,
	input  logic       tick_q4,
	input  logic       ack_sample,
	input  logic       ack_bit,
	input  logic [7:0] capture_byte,
	output logic [2:0] cur_sym,
	output logic       busy,
	output logic       done,
	output logic       rd_valid,
	output logic [7:0] rd_data,
	output logic       ack_failure,
	output logic [3:0] ack_history
);
	import i2c_bus_pkg::*;

	// head of the string sits in the top three bits
	logic [3*max_syms-1:0] sym_str;
	logic                  read_pending;
	logic                  stop_hit;
	logic [23:0]           addr_w_syms;
	logic [23:0]           addr_r_syms;
	logic [23:0]           mem_syms;
	logic [23:0]           data_syms;

	// one byte into eight send symbols, msb first
	function automatic logic [23:0] expand(input logic [7:0] b);
		logic [23:0] s;
		int          i;
		for (i = 0; i < 8; i++) begin
			s[3*i +: 3] = b[i] ? sym_send1 : sym_send0;
		end
		return s;
	endfunction

	// address byte carries r/w in bit 0
	assign addr_w_syms = expand({dev_addr, 1'b0});
	assign addr_r_syms = expand({dev_addr, 1'b1});
	assign mem_syms    = expand(mem_addr);
	assign data_syms   = expand(wr_data);

	assign cur_sym  = sym_str[3*max_syms-1 -: 3];
	// a new command takes over from the stop symbol
	assign stop_hit = busy && (cur_sym == sym_stop) && !cmd_wr && !cmd_rd;

	always_ff @(posedge clk or negedge user_mode_sync) begin
		if (!user_mode_sync) begin
			sym_str      <= {max_syms{sym_idle}};
			busy         <= 1'b0;
			done         <= 1'b0;
			rd_valid     <= 1'b0;
			read_pending <= 1'b0;
			ack_failure  <= 1'b0;
			ack_history  <= 4'h0;
		end else begin
			done     <= 1'b0;
			rd_valid <= 1'b0;
			if (cmd_wr) begin
				// 32 symbols, padded with idle
				sym_str <= {sym_idle, sym_idle, sym_start,
				            addr_w_syms, sym_check,
				            mem_syms, sym_check,
				            data_syms, sym_check,
				            sym_stop, sym_idle,
				            {12{sym_idle}}};
				busy         <= 1'b1;
				read_pending <= 1'b0;
				ack_failure  <= 1'b0;
			end else if (cmd_rd) begin
				// 42 symbols, repeated start before the read address
				sym_str <= {sym_idle, sym_idle, sym_start,
				            addr_w_syms, sym_check,
				            mem_syms, sym_check,
				            sym_start, addr_r_syms, sym_check,
				            {8{sym_grab}}, sym_send1,
				            sym_stop, sym_idle,
				            {2{sym_idle}}};
				busy         <= 1'b1;
				read_pending <= 1'b1;
				ack_failure  <= 1'b0;
			end else begin
				if (tick_q4) begin
					sym_str <= {sym_str[3*max_syms-4:0], sym_idle};
				end
				// sticky until the next command
				if (ack_sample && ack_bit) begin
					ack_failure <= 1'b1;
				end
			end
			if (stop_hit) begin
				busy <= 1'b0;
				done <= 1'b1;
				if (read_pending) begin
					rd_valid     <= 1'b1;
					read_pending <= 1'b0;
				end
			end
			if (ack_sample) begin
				ack_history <= {ack_history[2:0], ack_bit};
			end
		end
	end

	// read byte is complete once the nak has gone out
	always_ff @(posedge clk) begin
		if (stop_hit && read_pending) begin
			rd_data <= capture_byte;
		end
	end

endmodule

// ==== logic/i2c_bit_engine.sv ====
/*
 * i2c bit engine
 * drives open-drain scl/sda for the head symbol, captures read bits
 * and samples acknowledge bits
 */
`timescale 1ns/1ps

module i2c_bit_engine (
	input  logic       clk,
	input  logic       user_mode_sync,
	input  logic [2:0] cur_sym,
	input  logic       tick_q1,
	input  logic       tick_q2,
	input  logic       tick_q3,
	input  logic       tick_q4,
	input  logic       scl_in,
	input  logic       sda_in,
	output logic       scl_out,
	output logic       scl_oe,
	output logic       sda_out,
	output logic       sda_oe,
	output logic       ack_sample,
	output logic       ack_bit,
	output logic [7:0] capture_byte
);
	import i2c_bus_pkg::*;

	////////////////////
	// pin drive
	////////////////////

	always_ff @(posedge clk or negedge user_mode_sync) begin
		if (!user_mode_sync) begin
			scl_out    <= 1'b1;
			scl_oe     <= 1'b0;
			sda_out    <= 1'b1;
			sda_oe     <= 1'b0;
			ack_sample <= 1'b0;
		end else begin
			ack_sample <= 1'b0;
			// scl is held by the master for every active symbol
			scl_oe <= 1'b1;
			case (cur_sym)
				sym_idle: begin
					scl_out <= 1'b1;
					scl_oe  <= 1'b0;
					sda_out <= 1'b1;
					sda_oe  <= 1'b0;
				end
				sym_start: begin
					// sda high first, then falls with scl high
					if (tick_q1) begin
						sda_oe  <= 1'b1;
						sda_out <= 1'b1;
					end
					if (tick_q2) scl_out <= 1'b1;
					if (tick_q3) sda_out <= 1'b0;
					if (tick_q4) scl_out <= 1'b0;
				end
				sym_stop: begin
					// sda rises with scl high, scl stays up into idle
					if (tick_q1) begin
						sda_oe  <= 1'b1;
						sda_out <= 1'b0;
					end
					if (tick_q2) scl_out <= 1'b1;
					if (tick_q3) sda_out <= 1'b1;
				end
				sym_grab, sym_check: begin
					// slave owns sda for this bit
					sda_oe <= 1'b0;
					if (tick_q2) scl_out <= 1'b1;
					if (tick_q3 && (cur_sym == sym_check)) ack_sample <= 1'b1;
					if (tick_q4) scl_out <= 1'b0;
				end
				sym_send0, sym_send1: begin
					// data changes only while scl is low
					if (tick_q1) begin
						sda_oe  <= 1'b1;
						sda_out <= cur_sym[0];
					end
					if (tick_q2) scl_out <= 1'b1;
					if (tick_q4) scl_out <= 1'b0;
				end
				default: begin
					// unknown code, let the bus go
					scl_out <= 1'b1;
					scl_oe  <= 1'b0;
					sda_out <= 1'b1;
					sda_oe  <= 1'b0;
				end
			endcase
		end
	end

	////////////////////
	// sampling
	////////////////////

	always_ff @(posedge clk) begin
		// grab bits arrive msb first
		if (tick_q3 && (cur_sym == sym_grab)) begin
			capture_byte <= {capture_byte[6:0], sda_in};
		end
		// clock not seen high at the sample point counts as nak
		if (tick_q3 && (cur_sym == sym_check)) begin
			ack_bit <= sda_in | ~scl_in;
		end
	end

endmodule

// ==== logic/i2c_axil_regs.sv ====
/*
 * i2c master axi4-lite register file
 * holds address and data fields, issues commands and presents status
 */
`timescale 1ns/1ps

module i2c_axil_regs (
	input  logic                              clk,
	input  logic                              user_mode_sync,
	input  logic [i2c_ctrl_pkg::axi_addr_w-1:0] awaddr,
	input  logic                              awvalid,
	output logic                              awready,
	input  logic [i2c_ctrl_pkg::axi_data_w-1:0] wdata,
	input  logic [i2c_ctrl_pkg::axi_strb_w-1:0] wstrb,
	input  logic                              wvalid,
	output logic                              wready,
	output logic [1:0]                        bresp,
	output logic                              bvalid,
	input  logic                              bready,
	input  logic [i2c_ctrl_pkg::axi_addr_w-1:0] araddr,
	input  logic                              arvalid,
	output logic                              arready,
	output logic [i2c_ctrl_pkg::axi_data_w-1:0] rdata,
	output logic [1:0]                        rresp,
	output logic                              rvalid,
	input  logic                              rready,
	input  logic                              busy,
	input  logic                              done,
	input  logic                              rd_valid_in,
	input  logic [7:0]                        rd_data_in,
	input  logic                              ack_failure,
	input  logic [3:0]                        ack_history,
	output logic [6:0]                        dev_addr,
	output logic [7:0]                        mem_addr,
	output logic [7:0]                        wr_data,
	output logic                              cmd_wr,
	output logic                              cmd_rd
);
	import i2c_ctrl_pkg::*;

	logic                  wr_go;
	logic                  xfer_active;
	logic                  eng_busy;
	logic                  rd_sticky;
	logic [7:0]            rd_byte;
	logic [axi_data_w-1:0] status_word;
	logic [axi_data_w-1:0] rd_word;

	// covers the gap between the command pulse and busy rising
	assign eng_busy = busy | xfer_active;

	// both halves of the write must be present, none while a response waits
	assign wr_go = awvalid && wvalid && !awready && !bvalid;

	// no new read while a response is held
	assign arready = !rvalid;

	////////////////////
	// write channel
	////////////////////

	always_ff @(posedge clk or negedge user_mode_sync) begin
		if (!user_mode_sync) begin
			awready     <= 1'b0;
			wready      <= 1'b0;
			bvalid      <= 1'b0;
			bresp       <= resp_okay;
			cmd_wr      <= 1'b0;
			cmd_rd      <= 1'b0;
			xfer_active <= 1'b0;
			dev_addr    <= 7'h0;
			mem_addr    <= 8'h0;
			wr_data     <= 8'h0;
			rd_sticky   <= 1'b0;
			rd_byte     <= 8'h0;
		end else begin
			awready <= wr_go;
			wready  <= wr_go;
			cmd_wr  <= 1'b0;
			cmd_rd  <= 1'b0;
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (done) begin
				xfer_active <= 1'b0;
			end
			if (rd_valid_in) begin
				rd_sticky <= 1'b1;
				rd_byte   <= rd_data_in;
			end
			// awready high marks the handshake cycle
			if (awready) begin
				bvalid <= 1'b1;
				bresp  <= resp_okay;
				case (awaddr)
					reg_dev_addr: if (wstrb[0]) dev_addr <= wdata[7:dev_addr_lsb];
					reg_mem_addr: if (wstrb[0]) mem_addr <= wdata[7:0];
					reg_wr_data:  if (wstrb[0]) wr_data  <= wdata[7:0];
					reg_command: begin
						if (eng_busy) begin
							// dropped, transfer in flight keeps running
							bresp <= resp_slverr;
						end else if (wstrb[0] && (wdata[cmd_wr_bit] || wdata[cmd_rd_bit])) begin
							cmd_wr      <= wdata[cmd_wr_bit];
							cmd_rd      <= !wdata[cmd_wr_bit];
							xfer_active <= 1'b1;
							rd_sticky   <= 1'b0;
							rd_byte     <= 8'h0;
						end
					end
					default: ;
				endcase
			end
		end
	end

	////////////////////
	// read channel
	////////////////////

	always_comb begin
		status_word                     = '0;
		status_word[st_busy_bit]        = eng_busy;
		status_word[st_fail_bit]        = ack_failure;
		status_word[st_hist_lsb +: 4]   = ack_history;
		status_word[st_rdv_bit]         = rd_sticky;
		status_word[st_rdd_lsb +: 8]    = rd_byte;
	end

	// command is write only, so it reads zero with the unmapped space
	always_comb begin
		rd_word = '0;
		case (araddr)
			reg_dev_addr: rd_word[7:dev_addr_lsb] = dev_addr;
			reg_mem_addr: rd_word[7:0] = mem_addr;
			reg_wr_data:  rd_word[7:0] = wr_data;
			reg_status:   rd_word = status_word;
			default:      rd_word = '0;
		endcase
	end

	always_ff @(posedge clk or negedge user_mode_sync) begin
		if (!user_mode_sync) begin
			rvalid <= 1'b0;
			rresp  <= resp_okay;
			rdata  <= '0;
		end else begin
			if (arvalid && arready) begin
				rvalid <= 1'b1;
				rresp  <= resp_okay;
				rdata  <= rd_word;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

endmodule

// ==== logic/i2c_master_top.sv ====
/*
 * i2c master top level
 * axi4-lite register file driving a timed symbol sequencer and bit engine
 */
`timescale 1ns/1ps

module i2c_master_top (
	input  logic                              clk,
	input  logic                              user_mode_sync,
	input  logic [i2c_ctrl_pkg::axi_addr_w-1:0] awaddr,
	input  logic                              awvalid,
	output logic                              awready,
	input  logic [i2c_ctrl_pkg::axi_data_w-1:0] wdata,
	input  logic [i2c_ctrl_pkg::axi_strb_w-1:0] wstrb,
	input  logic                              wvalid,
	output logic                              wready,
	output logic [1:0]                        bresp,
	output logic                              bvalid,
	input  logic                              bready,
	input  logic [i2c_ctrl_pkg::axi_addr_w-1:0] araddr,
	input  logic                              arvalid,
	output logic                              arready,
	output logic [i2c_ctrl_pkg::axi_data_w-1:0] rdata,
	output logic [1:0]                        rresp,
	output logic                              rvalid,
	input  logic                              rready,
	input  logic                              scl_in,
	input  logic                              sda_in,
	output logic                              scl_out,
	output logic                              scl_oe,
	output logic                              sda_out,
	output logic                              sda_oe
);

	// register file to sequencer
	logic [6:0] dev_addr;
	logic [7:0] mem_addr;
	logic [7:0] wr_data;
	logic       cmd_wr;
	logic       cmd_rd;

	// sequencer status
	logic       busy;
	logic       done;
	logic       rd_valid;
	logic [7:0] rd_data;
	logic       ack_failure;
	logic [3:0] ack_history;

	// timing and bit level
	logic       tick_q1;
	logic       tick_q2;
	logic       tick_q3;
	logic       tick_q4;
	logic [2:0] cur_sym;
	logic       ack_sample;
	logic       ack_bit;
	logic [7:0] capture_byte;

	i2c_axil_regs i2c_axil_regs_i (
		.clk            (clk),
		.user_mode_sync (user_mode_sync),
		.awaddr         (awaddr),
		.awvalid        (awvalid),
		.awready        (awready),
		.wdata          (wdata),
		.wstrb          (wstrb),
		.wvalid         (wvalid),
		.wready         (wready),
		.bresp          (bresp),
		.bvalid         (bvalid),
		.bready         (bready),
		.araddr         (araddr),
		.arvalid        (arvalid),
		.arready        (arready),
		.rdata          (rdata),
		.rresp          (rresp),
		.rvalid         (rvalid),
		.rready         (rready),
		.busy           (busy),
		.done           (done),
		.rd_valid_in    (rd_valid),
		.rd_data_in     (rd_data),
		.ack_failure    (ack_failure),
		.ack_history    (ack_history),
		.dev_addr       (dev_addr),
		.mem_addr       (mem_addr),
		.wr_data        (wr_data),
		.cmd_wr         (cmd_wr),
		.cmd_rd         (cmd_rd)
	);

	i2c_bit_timer i2c_bit_timer_i (
		.clk            (clk),
		.user_mode_sync (user_mode_sync),
		.tick_q1        (tick_q1),
		.tick_q2        (tick_q2),
		.tick_q3        (tick_q3),
		.tick_q4        (tick_q4)
	);

	i2c_sequencer i2c_sequencer_i (
		.clk            (clk),
		.user_mode_sync (user_mode_sync),
		.cmd_wr         (cmd_wr),
		.cmd_rd         (cmd_rd),
		.dev_addr       (dev_addr),
		.mem_addr       (mem_addr),
		.wr_data        (wr_data),
		.tick_q4        (tick_q4),
		.ack_sample     (ack_sample),
		.ack_bit        (ack_bit),
		.capture_byte   (capture_byte),
		.cur_sym        (cur_sym),
		.busy           (busy),
		.done           (done),
		.rd_valid       (rd_valid),
		.rd_data        (rd_data),
		.ack_failure    (ack_failure),
		.ack_history    (ack_history)
	);

	i2c_bit_engine i2c_bit_engine_i (
		.clk            (clk),
		.user_mode_sync (user_mode_sync),
		.cur_sym        (cur_sym),
		.tick_q1        (tick_q1),
		.tick_q2        (tick_q2),
		.tick_q3        (tick_q3),
		.tick_q4        (tick_q4),
		.scl_in         (scl_in),
		.sda_in         (sda_in),
		.scl_out        (scl_out),
		.scl_oe         (scl_oe),
		.sda_out        (sda_out),
		.sda_oe         (sda_oe),
		.ack_sample     (ack_sample),
		.ack_bit        (ack_bit),
		.capture_byte   (capture_byte)
	);

endmodule

// ==== verification/i2c_slave_model.sv ====
/*
 * i2c register device model
 * 256-byte register space at one 7-bit address, acknowledges its own
 * address and every byte, stores writes and returns reads
 */
`timescale 1ns/1ps

module i2c_slave_model #(
	parameter logic [6:0] dev_addr = 7'h50
) (
	input  logic scl,
	input  logic sda,
	output logic sda_pull
);

	// bus phases seen by the device
	localparam int ph_idle = 0;
	localparam int ph_rx   = 1;
	localparam int ph_ack  = 2;
	localparam int ph_tx   = 3;
	localparam int ph_mack = 4;

	logic [7:0] mem [256];
	logic [7:0] shreg;
	logic [7:0] ptr;
	logic       scl_q;
	logic       sda_q;
	logic       selected;
	logic       rw;
	int         phase;
	int         bit_cnt;
	int         byte_idx;

	initial begin
		// power-up contents depend on every address bit
		for (int i = 0; i < 256; i++) begin
			mem[i] = {8'(i) << 4 | 8'(i) >> 4} ^ 8'h3c;
		end
		sda_pull = 1'b0;
		scl_q    = 1'b1;
		sda_q    = 1'b1;
		selected = 1'b0;
		rw       = 1'b0;
		ptr      = 8'h0;
		shreg    = 8'h0;
		phase    = ph_idle;
		bit_cnt  = 0;
		byte_idx = 0;
	end

	always @(scl or sda) begin
		if (scl === 1'b1 && scl_q === 1'b1 && sda === 1'b0 && sda_q === 1'b1) begin
			// start or repeated start, register pointer survives
			phase    = ph_rx;
			bit_cnt  = 0;
			byte_idx = 0;
			sda_pull = 1'b0;
		end else if (scl === 1'b1 && scl_q === 1'b1 && sda === 1'b1 && sda_q === 1'b0) begin
			// stop
			phase    = ph_idle;
			sda_pull = 1'b0;
		end else if (scl === 1'b1 && scl_q === 1'b0) begin
			// data is valid while scl is high
			if (phase == ph_rx) begin
				shreg   = {shreg[6:0], sda};
				bit_cnt = bit_cnt + 1;
			end
		end else if (scl === 1'b0 && scl_q === 1'b1) begin
			// sda may only move while scl is low
			case (phase)
				ph_rx: begin
					if (bit_cnt == 8) begin
						bit_cnt = 0;
						if (byte_idx == 0) begin
							selected = (shreg[7:1] == dev_addr);
							rw       = shreg[0];
						end else if (selected && byte_idx == 1) begin
							ptr = shreg;
						end else if (selected) begin
							mem[ptr] = shreg;
							ptr      = ptr + 8'h1;
						end
						byte_idx = byte_idx + 1;
						if (selected) begin
							sda_pull = 1'b1;
							phase    = ph_ack;
						end else begin
							phase = ph_idle;
						end
					end
				end
				ph_ack: begin
					sda_pull = 1'b0;
					if (rw) begin
						// first read bit goes out right after the ack
						shreg    = mem[ptr];
						ptr      = ptr + 8'h1;
						bit_cnt  = 0;
						sda_pull = !shreg[7];
						phase    = ph_tx;
					end else begin
						phase = ph_rx;
					end
				end
				ph_tx: begin
					bit_cnt = bit_cnt + 1;
					if (bit_cnt == 8) begin
						sda_pull = 1'b0;
						phase    = ph_mack;
					end else begin
						sda_pull = !shreg[7-bit_cnt];
					end
				end
				ph_mack: phase = ph_idle;
				default: phase = ph_idle;
			endcase
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

// ==== verification/i2c_master_asserts.sv ====
/*
 * i2c master bus assertions
 * bus protocol and sequencing checks on the sequencer and bit engine
 */
`timescale 1ns/1ps

module i2c_master_asserts (
	input logic       clk,
	input logic       user_mode_sync,
	input logic [2:0] cur_sym,
	input logic       busy,
	input logic       done,
	input logic       scl_in,
	input logic       sda_in,
	input logic       scl_out,
	input logic       scl_oe,
	input logic       sda_out,
	input logic       sda_oe
);
	import i2c_bus_pkg::*;

	// sda moves under a high scl only for start and stop
	sda_stable_a: assert property (@(posedge clk) disable iff (!user_mode_sync)
		(scl_oe && scl_out && $past(scl_oe && scl_out) && sda_oe && $past(sda_oe)
		 && (sda_out != $past(sda_out)))
		|-> ($past(cur_sym) == sym_start || $past(cur_sym) == sym_stop))
		else $error("sda changed while scl high outside start or stop");

	// done closes a transfer that was already running a bit period earlier
	done_after_busy_a: assert property (@(posedge clk) disable iff (!user_mode_sync)
		done |-> $past(busy, bit_cycle))
		else $error("done pulsed without a running transfer");

	// idle head leaves both pins released and both lines pulled high
	idle_release_a: assert property (@(posedge clk) disable iff (!user_mode_sync)
		($past(cur_sym) == sym_idle) |-> (!scl_oe && !sda_oe && scl_in && sda_in))
		else $error("bus not released while head symbol idle");

endmodule

bind i2c_master_top i2c_master_asserts i2c_master_asserts_i (.*);

// ==== verification/i2c_master_tb.sv ====
/*
 * i2c master testbench
 * axi4-lite host, wired-and bus with a register device, reference
 * model of status and read data, compare process and watchdog
 */
`timescale 1ns/1ps

module i2c_master_tb;
	import i2c_ctrl_pkg::*;
	import i2c_bus_pkg::*;

	localparam logic [6:0] slave_addr   = 7'h50;
	localparam logic [6:0] missing_addr = 7'h51;
	localparam int         num_xfers    = 14;
	// each transfer fits in 44 bit periods of 100 ns clocks, doubled
	localparam longint     wd_limit     = longint'(num_xfers) * 44 * bit_cycle * 100 * 2;

	logic                  clk;
	logic                  user_mode_sync;
	logic [axi_addr_w-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [axi_data_w-1:0] wdata;
	logic [axi_strb_w-1:0] wstrb;
	logic                  wvalid;
	logic                  wready;
	logic [1:0]            bresp;
	logic                  bvalid;
	logic                  bready;
	logic [axi_addr_w-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic [axi_data_w-1:0] rdata;
	logic [1:0]            rresp;
	logic                  rvalid;
	logic                  rready;
	logic                  scl_out;
	logic                  scl_oe;
	logic                  sda_out;
	logic                  sda_oe;
	logic                  slave_pull;
	logic                  scl_bus;
	logic                  sda_bus;

	// transfers run since reset
	logic [6:0] xfer_dev [$];
	logic       xfer_rd [$];
	logic [7:0] xfer_mem [$];
	logic [7:0] xfer_data [$];

	int   seed;
	event cmd_issued;
	event cmp_done;

	// wired-and with pull-ups
	assign scl_bus = scl_oe ? scl_out : 1'b1;
	assign sda_bus = (sda_oe ? sda_out : 1'b1) & ~slave_pull;

	i2c_master_top i2c_master_top_i (
		.clk(clk), .user_mode_sync(user_mode_sync),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.scl_in(scl_bus), .sda_in(sda_bus),
		.scl_out(scl_out), .scl_oe(scl_oe), .sda_out(sda_out), .sda_oe(sda_oe)
	);

	i2c_slave_model #(.dev_addr(slave_addr)) i2c_slave_model_i (
		.scl(scl_bus), .sda(sda_bus), .sda_pull(slave_pull)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////
	// reference model
	////////////////////

	// device power-up contents
	function automatic logic [7:0] fill_byte(input logic [7:0] a);
		return {a[3:0], a[7:4]} ^ 8'h3c;
	endfunction

	function automatic logic [7:0] exp_read(input logic [7:0] mirror [256], input logic [7:0] a);
		return mirror[a];
	endfunction

	// replays every transfer, three checks each, all nak without a device
	function automatic logic [31:0] exp_status();
		logic [7:0]  mirror [256];
		logic [3:0]  hist;
		logic        fail;
		logic        rdv;
		logic [7:0]  rdd;
		logic        ok;
		logic [31:0] st;
		for (int i = 0; i < 256; i++) mirror[i] = fill_byte(8'(i));
		hist = 4'h0;
		fail = 1'b0;
		rdv  = 1'b0;
		rdd  = 8'h0;
		for (int i = 0; i < xfer_dev.size(); i++) begin
			ok   = (xfer_dev[i] == slave_addr);
			fail = !ok;
			for (int k = 0; k < 3; k++) hist = {hist[2:0], !ok};
			rdv = xfer_rd[i];
			rdd = 8'h0;
			if (xfer_rd[i]) begin
				// released bus reads all ones
				rdd = ok ? exp_read(mirror, xfer_mem[i]) : 8'hff;
			end else if (ok) begin
				mirror[xfer_mem[i]] = xfer_data[i];
			end
		end
		st                  = '0;
		st[st_fail_bit]     = fail;
		st[st_hist_lsb +: 4] = hist;
		st[st_rdv_bit]      = rdv;
		st[st_rdd_lsb +: 8] = rdd;
		return st;
	endfunction

	////////////////////
	// host side
	////////////////////

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// hold keeps bready low for that many cycles once bvalid is up
	task automatic axi_write(input logic [4:0] addr, input logic [31:0] data, input int hold,
		output logic [1:0] resp);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!awready);
		check("wready", 32'h1, 32'(wready));
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid) begin
			@(posedge clk);
			#1;
		end
		resp = bresp;
		repeat (hold) begin
			@(posedge clk);
			#1;
			check("bvalid held", 32'h1, 32'(bvalid));
			check("bresp held", 32'(resp), 32'(bresp));
		end
		bready = 1'b1;
		@(posedge clk);
		#1;
		bready = 1'b0;
		check("bvalid cleared", 32'h0, 32'(bvalid));
	endtask

	task automatic axi_read(input logic [4:0] addr, input int hold, output logic [31:0] data);
		araddr  = addr;
		arvalid = 1'b1;
		check("arready idle", 32'h1, 32'(arready));
		do begin
			@(posedge clk);
			#1;
		end while (!rvalid);
		arvalid = 1'b0;
		data    = rdata;
		check("rresp", 32'(resp_okay), 32'(rresp));
		// no new address taken while the response waits
		check("arready while rvalid", 32'h0, 32'(arready));
		repeat (hold) begin
			@(posedge clk);
			#1;
			check("rvalid held", 32'h1, 32'(rvalid));
			check("rdata held", data, rdata);
		end
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic load_fields(input logic [6:0] dev, input logic [7:0] mem, input logic [7:0] d);
		logic [1:0] resp;
		axi_write(reg_dev_addr, 32'({dev, 1'b0}), 0, resp);
		check("dev_addr field bresp", 32'(resp_okay), 32'(resp));
		axi_write(reg_mem_addr, 32'(mem), 0, resp);
		check("mem_addr field bresp", 32'(resp_okay), 32'(resp));
		axi_write(reg_wr_data, 32'(d), 0, resp);
		check("field bresp", 32'(resp_okay), 32'(resp));
	endtask

	task automatic issue_cmd(input logic [6:0] dev, input logic [7:0] mem, input logic [7:0] d,
		input logic rd);
		logic [1:0] resp;
		axi_write(reg_command, rd ? 32'h2 : 32'h1, 0, resp);
		check("command bresp", 32'(resp_okay), 32'(resp));
		xfer_dev.push_back(dev);
		xfer_rd.push_back(rd);
		xfer_mem.push_back(mem);
		xfer_data.push_back(d);
	endtask

	task automatic await_compare();
		-> cmd_issued;
		@(cmp_done);
	endtask

	task automatic write_xfer(input logic [6:0] dev, input logic [7:0] mem, input logic [7:0] d);
		load_fields(dev, mem, d);
		issue_cmd(dev, mem, d, 1'b0);
		await_compare();
	endtask

	task automatic read_xfer(input logic [6:0] dev, input logic [7:0] mem);
		load_fields(dev, mem, 8'h0);
		issue_cmd(dev, mem, 8'h0, 1'b1);
		await_compare();
	endtask

	// stop condition still runs for one bit period after busy drops
	task automatic wait_bus_idle();
		int n;
		n = 0;
		while ((scl_oe || sda_oe) && n < 2 * bit_cycle) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (scl_oe || sda_oe) begin
			$display("bus still driven two bit periods after the transfer ended");
			$display("Errors found");
			$fatal(1);
		end
		check("scl idle level", 32'h1, 32'(scl_bus));
		check("sda idle level", 32'h1, 32'(sda_bus));
	endtask

	task automatic regs_test(input int hold);
		logic [1:0]  resp;
		logic [31:0] rd;
		axi_write(reg_dev_addr, 32'ha1, hold, resp);
		check("dev_addr bresp", 32'(resp_okay), 32'(resp));
		axi_write(reg_mem_addr, 32'h3c, hold, resp);
		axi_write(reg_wr_data, 32'hc7, hold, resp);
		// bit 0 of the device word is not stored
		axi_read(reg_dev_addr, hold, rd);
		check("dev_addr readback", 32'ha0, rd);
		axi_read(reg_mem_addr, hold, rd);
		check("mem_addr readback", 32'h3c, rd);
		axi_read(reg_wr_data, hold, rd);
		check("wr_data readback", 32'hc7, rd);
		axi_read(5'h14, hold, rd);
		check("unmapped 0x14", 32'h0, rd);
		axi_read(5'h1c, hold, rd);
		check("unmapped 0x1c", 32'h0, rd);
	endtask

	////////////////////
	// compare process
	////////////////////

	initial begin
		logic [31:0] st;
		forever begin
			@(cmd_issued);
			do begin
				axi_read(reg_status, 0, st);
			end while (st[st_busy_bit]);
			wait_bus_idle();
			check("status", exp_status(), st);
			-> cmp_done;
		end
	end

	initial begin
		#(wd_limit);
		$display("watchdog expired before all transfers finished");
		$display("Errors found");
		$fatal(1);
	end

	////////////////////
	// stimulus
	////////////////////

	initial begin
		logic [7:0] m;
		logic [7:0] d;
		logic [1:0] resp;
		seed           = 32'hca742ee9;
		user_mode_sync = 1'b0;
		awaddr         = '0;
		awvalid        = 1'b0;
		wdata          = '0;
		wstrb          = '0;
		wvalid         = 1'b0;
		bready         = 1'b0;
		araddr         = '0;
		arvalid        = 1'b0;
		rready         = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		user_mode_sync = 1'b1;
		check("scl_oe after reset", 32'h0, 32'(scl_oe));
		check("sda_oe after reset", 32'h0, 32'(sda_oe));
		check("scl after reset", 32'h1, 32'(scl_bus));
		check("sda after reset", 32'h1, 32'(sda_bus));

		// readback, then the same with held responses
		regs_test(0);
		regs_test(5);

		// write then read at the device
		for (int i = 0; i < 4; i++) begin
			m = 8'($random(seed));
			d = 8'($random(seed));
			write_xfer(slave_addr, m, d);
			read_xfer(slave_addr, m);
		end

		// nobody answers at 0x51
		m = 8'($random(seed));
		d = 8'($random(seed));
		write_xfer(missing_addr, m, d);
		read_xfer(missing_addr, m);

		// recovery after the failure
		m = 8'($random(seed));
		d = 8'($random(seed));
		write_xfer(slave_addr, m, d);
		read_xfer(slave_addr, m);

		// second command while busy is refused, string already loaded
		m = 8'($random(seed));
		d = 8'($random(seed));
		load_fields(slave_addr, m, d);
		issue_cmd(slave_addr, m, d, 1'b0);
		axi_write(reg_wr_data, 32'(~d), 0, resp);
		axi_write(reg_command, 32'h1, 0, resp);
		check("busy command bresp", 32'(resp_slverr), 32'(resp));
		await_compare();
		read_xfer(slave_addr, m);

		$display("No errors");
		$finish;
	end

endmodule

// ==== flist.f ====
logic/i2c_ctrl_pkg.sv
logic/i2c_bus_pkg.sv
logic/i2c_bit_timer.sv
logic/i2c_sequencer.sv
logic/i2c_bit_engine.sv
logic/i2c_axil_regs.sv
logic/i2c_master_top.sv
verification/i2c_slave_model.sv
verification/i2c_master_asserts.sv
verification/i2c_master_tb.sv

// ==== Makefile ====
# Verilator build and run of the i2c master testbench

SIM = i2c_master_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -f flist.f --top-module i2c_master_tb -o $(SIM)
	./obj_dir/$(SIM)

clean:
	rm -rf obj_dir
